/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mailbox
FILELIST  ?= project.f
BUILD     ?= build
LOG       ?= $(BUILD)/sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST PASSED

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/mailbox_macros.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST) -o V$(TOP)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD)

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic sys,
    output logic reset
);

    initial begin
        sys = 1'b0;
        forever #(PERIOD / 2) sys = ~sys;
    end

    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge sys);
        reset <= 1'b0;  // released on a rising edge.
    end

endmodule

/* bench/tb_mailbox.sv */
`timescale 1ns/1ps
`include "mailbox_macros.svh"

module tb_mailbox;

    import mailbox_pkg::*;

    localparam int CYCLE_LIMIT = 4000;  // sequence runs about 1000 cycles.

    logic       sys;
    logic       reset;
    logic       host_cyc;
    logic       host_stb;
    logic       host_we;
    host_addr_t host_adr;
    host_word_t host_dat_w;
    host_word_t host_dat_r;
    logic       host_ack;
    logic       ctrl_cyc;
    logic       ctrl_stb;
    logic       ctrl_we;
    ctrl_addr_t ctrl_adr;
    ctrl_word_t ctrl_dat_w;
    ctrl_word_t ctrl_dat_r;
    logic       ctrl_ack;
    logic       cmd_request;
    logic       host_check;
    host_word_t host_ref;
    logic       ctrl_check;
    ctrl_word_t ctrl_ref;
    int         data_errors;
    int         protocol_errors;
    int         cycles = 0;
    integer     seed   = 32'hae8c;

    // reference model.
    command_t   m_cmd   = '0;
    ctrl_word_t m_data0 = '0;
    ctrl_word_t m_data1 = '0;
    logic       m_ready = 1'b0;
    logic       m_busy  = 1'b0;

    tb_clock_gen u_clock (.sys(sys), .reset(reset));
    mailbox_top u_dut (.*);
    tb_mailbox_checks u_checks (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model lookups and updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic host_word_t host_model(input host_addr_t adr);
        ctrl_word_t version;
        version = `MAILBOX_VERSION;
        case (adr)
            `H_STATUS:    return {m_ready, m_busy, 14'd0};
            `H_COMMAND:   return {8'd0, m_cmd};
            `H_DATA0_H:   return m_data0[31:16];
            `H_DATA0_L:   return m_data0[15:0];
            `H_DATA1_H:   return m_data1[31:16];
            `H_DATA1_L:   return m_data1[15:0];
            `H_VERSION_H: return version[31:16];
            default:      return version[15:0];
        endcase
    endfunction

    function automatic ctrl_word_t ctrl_model(input ctrl_addr_t adr);
        case (adr)
            `C_STATUS:  return {30'd0, m_busy, m_ready};
            `C_COMMAND: return {24'd0, m_cmd};
            `C_DATA0:   return m_data0;
            default:    return m_data1;
        endcase
    endfunction

    task automatic host_apply(input host_addr_t adr, input host_word_t dat);
        case (adr)
            `H_COMMAND: begin
                m_cmd  = dat[7:0];
                m_busy = 1'b1;
            end
            `H_DATA0_H: m_data0[31:16] = dat;
            `H_DATA0_L: m_data0[15:0]  = dat;
            `H_DATA1_H: m_data1[31:16] = dat;
            `H_DATA1_L: m_data1[15:0]  = dat;
            default: ;
        endcase
    endtask

    task automatic ctrl_apply(input ctrl_addr_t adr, input ctrl_word_t dat);
        case (adr)
            `C_STATUS: begin
                m_ready = dat[0];
                if (dat[1]) m_busy = 1'b0;
            end
            `C_DATA0: m_data0 = dat;
            `C_DATA1: m_data1 = dat;
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus masters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic host_cycle(input logic we, input host_addr_t adr, input host_word_t wdat,
                              input logic check, input host_word_t ref_dat);
        @(posedge sys);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= we;
        host_adr   <= adr;
        host_dat_w <= wdat;
        host_check <= check;
        host_ref   <= ref_dat;
        do @(posedge sys); while (!host_ack);
        host_cyc   <= 1'b0;
        host_stb   <= 1'b0;
        host_check <= 1'b0;
    endtask

    task automatic ctrl_cycle(input logic we, input ctrl_addr_t adr, input ctrl_word_t wdat,
                              input logic check, input ctrl_word_t ref_dat);
        @(posedge sys);
        ctrl_cyc   <= 1'b1;
        ctrl_stb   <= 1'b1;
        ctrl_we    <= we;
        ctrl_adr   <= adr;
        ctrl_dat_w <= wdat;
        ctrl_check <= check;
        ctrl_ref   <= ref_dat;
        do @(posedge sys); while (!ctrl_ack);
        ctrl_cyc   <= 1'b0;
        ctrl_stb   <= 1'b0;
        ctrl_check <= 1'b0;
    endtask

    task automatic host_read(input host_addr_t adr);
        host_cycle(1'b0, adr, '0, 1'b1, host_model(adr));
    endtask

    task automatic host_write(input host_addr_t adr, input host_word_t dat);
        host_cycle(1'b1, adr, dat, 1'b0, '0);
        host_apply(adr, dat);
    endtask

    task automatic ctrl_read(input ctrl_addr_t adr);
        ctrl_cycle(1'b0, adr, '0, 1'b1, ctrl_model(adr));
    endtask

    task automatic ctrl_write(input ctrl_addr_t adr, input ctrl_word_t dat);
        ctrl_cycle(1'b1, adr, dat, 1'b0, '0);
        ctrl_apply(adr, dat);
    endtask

    task automatic read_all_data;
        int j;
        for (j = 2; j < 6; j++) host_read(j[2:0]);
        ctrl_read(`C_DATA0);
        ctrl_read(`C_DATA1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int         i;
        logic [31:0] r;
        logic [31:0] r2;
        ctrl_addr_t ca;
        host_cyc   <= 1'b0;
        host_stb   <= 1'b0;
        host_we    <= 1'b0;
        host_adr   <= '0;
        host_dat_w <= '0;
        host_check <= 1'b0;
        host_ref   <= '0;
        ctrl_cyc   <= 1'b0;
        ctrl_stb   <= 1'b0;
        ctrl_we    <= 1'b0;
        ctrl_adr   <= '0;
        ctrl_dat_w <= '0;
        ctrl_check <= 1'b0;
        ctrl_ref   <= '0;
        @(posedge sys);
        while (reset) @(posedge sys);

        for (i = 0; i < 8; i++) host_read(i[2:0]);  // version and reset values.
        for (i = 0; i < 4; i++) ctrl_read(i[1:0]);

        for (i = 0; i < 24; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            host_write(`H_DATA0_H, r[31:16]);
            host_write(`H_DATA0_L, r[15:0]);
            host_write(`H_DATA1_L, r2[15:0]);
            host_write(`H_DATA1_H, r2[31:16]);
            read_all_data();
        end

        r = $random(seed);
        host_write(`H_COMMAND, {8'd0, r[7:0]});
        host_read(`H_STATUS);
        host_read(`H_COMMAND);
        ctrl_read(`C_STATUS);
        ctrl_read(`C_COMMAND);

        for (i = 0; i < 4; i++) begin  // every ready and clear combination.
            r = $random(seed);
            host_write(`H_COMMAND, {8'd0, r[7:0]});
            ctrl_write(`C_STATUS, {30'd0, i[1:0]});
            host_read(`H_STATUS);
            ctrl_read(`C_STATUS);
        end

        for (i = 0; i < 8; i++) begin
            ctrl_write(`C_DATA0, $random(seed));
            ctrl_write(`C_DATA1, $random(seed));
            read_all_data();
        end

        // same word from both sides in one cycle.
        for (i = 2; i < 6; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            ca = (i < 4) ? `C_DATA0 : `C_DATA1;
            fork
                host_cycle(1'b1, i[2:0], r[15:0], 1'b0, '0);
                ctrl_cycle(1'b1, ca, r2, 1'b0, '0);
            join
            ctrl_apply(ca, r2);
            host_apply(i[2:0], r[15:0]);
            read_all_data();
        end

        repeat (2) @(posedge sys);
        $display("errors: data %0d, protocol %0d", data_errors, protocol_errors);
        if (data_errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge sys) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: test sequence did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

/* bench/tb_mailbox_checks.sv */
`timescale 1ns/1ps
`include "mailbox_macros.svh"

module tb_mailbox_checks (
    input  logic                    sys,
    input  logic                    reset,
    input  logic                    host_cyc,
    input  logic                    host_stb,
    input  logic                    host_we,
    input  mailbox_pkg::host_addr_t host_adr,
    input  mailbox_pkg::host_word_t host_dat_r,
    input  logic                    host_ack,
    input  logic                    ctrl_cyc,
    input  logic                    ctrl_stb,
    input  mailbox_pkg::ctrl_word_t ctrl_dat_r,
    input  logic                    ctrl_ack,
    input  logic                    cmd_request,
    input  logic                    host_check,
    input  mailbox_pkg::host_word_t host_ref,
    input  logic                    ctrl_check,
    input  mailbox_pkg::ctrl_word_t ctrl_ref,
    output int                      data_errors,
    output int                      protocol_errors
);

    initial begin
        data_errors     = 0;
        protocol_errors = 0;
    end

    task automatic note_data_error(input string msg);
        data_errors = data_errors + 1;
        $display("** Error @ %0t ns: %s", $time, msg);
    endtask

    task automatic note_protocol_error(input string msg);
        protocol_errors = protocol_errors + 1;
        $display("** Error @ %0t ns: %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read data against the reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_host_data: assert property (@(posedge sys) disable iff (reset)
        (host_ack && host_check) |-> host_dat_r == host_ref)
        else note_data_error($sformatf("host read %h, expected %h",
                                       $sampled(host_dat_r), $sampled(host_ref)));

    a_ctrl_data: assert property (@(posedge sys) disable iff (reset)
        (ctrl_ack && ctrl_check) |-> ctrl_dat_r == ctrl_ref)
        else note_data_error($sformatf("controller read %h, expected %h",
                                       $sampled(ctrl_dat_r), $sampled(ctrl_ref)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_reset_idle: assert property (@(posedge sys)
        $fell(reset) |-> !host_ack && !ctrl_ack && !cmd_request)
        else note_protocol_error("ack or command request high after reset");

    a_host_ack_once: assert property (@(posedge sys) disable iff (reset)
        host_ack |=> !host_ack)
        else note_protocol_error("host ack lasted more than one cycle");

    a_host_ack_follows: assert property (@(posedge sys) disable iff (reset)
        (host_cyc && host_stb && !host_ack) |=> host_ack)
        else note_protocol_error("host ack missing one edge after stb");

    a_host_ack_cause: assert property (@(posedge sys) disable iff (reset)
        host_ack |-> $past(host_cyc && host_stb && !host_ack))
        else note_protocol_error("host ack without a preceding strobe");

    a_host_quiet: assert property (@(posedge sys) disable iff (reset)
        !host_ack |-> host_dat_r == '0)
        else note_protocol_error("host read data not zero outside ack");

    a_cmd_pulse: assert property (@(posedge sys) disable iff (reset)
        cmd_request == (host_ack && host_we && host_adr == `H_COMMAND))
        else note_protocol_error("command request not matched to a command write ack");

    a_ctrl_ack_once: assert property (@(posedge sys) disable iff (reset)
        ctrl_ack |=> !ctrl_ack)
        else note_protocol_error("controller ack lasted more than one cycle");

    a_ctrl_ack_follows: assert property (@(posedge sys) disable iff (reset)
        (ctrl_cyc && ctrl_stb && !ctrl_ack) |=> ctrl_ack)
        else note_protocol_error("controller ack missing one edge after stb");

    a_ctrl_ack_cause: assert property (@(posedge sys) disable iff (reset)
        ctrl_ack |-> $past(ctrl_cyc && ctrl_stb && !ctrl_ack))
        else note_protocol_error("controller ack without a preceding strobe");

    a_ctrl_quiet: assert property (@(posedge sys) disable iff (reset)
        !ctrl_ack |-> ctrl_dat_r == '0)
        else note_protocol_error("controller read data not zero outside ack");

endmodule

/* logic/controller_port.sv */
`timescale 1ns/1ps
`include "mailbox_macros.svh"

module controller_port (
    input  logic                    sys,
    input  logic                    reset,
    input  logic                    ctrl_cyc,
    input  logic                    ctrl_stb,
    input  logic                    ctrl_we,
    input  mailbox_pkg::ctrl_addr_t ctrl_adr,
    input  mailbox_pkg::ctrl_word_t ctrl_dat_w,
    output mailbox_pkg::ctrl_word_t ctrl_dat_r,
    output logic                    ctrl_ack,
    input  mailbox_pkg::command_t   cmd,
    input  logic                    cmd_request,
    input  mailbox_pkg::ctrl_word_t data0,
    input  mailbox_pkg::ctrl_word_t data1,
    output logic [1:0]              data_write,
    output mailbox_pkg::ctrl_word_t data_wdata,
    output logic                    cpu_ready,
    output logic                    cpu_busy
);

    import mailbox_pkg::*;

    port_state_t state;
    logic        ctrl_access;
    logic        ctrl_write;

    assign ctrl_access = (state == port_idle) && ctrl_cyc && ctrl_stb;
    assign ctrl_write  = ctrl_access && ctrl_we;

    // data words live in the register block, strobe them across.
    always_comb begin
        data_write = 2'b00;
        if (ctrl_write) begin
            data_write[0] = (ctrl_adr == `C_DATA0);
            data_write[1] = (ctrl_adr == `C_DATA1);
        end
    end

    assign data_wdata = ctrl_dat_w;

    always_comb begin
        ctrl_dat_r = '0;
        if (ctrl_ack) begin
            case (ctrl_adr)
                `C_STATUS:  ctrl_dat_r = {30'd0, cpu_busy, cpu_ready};
                `C_COMMAND: ctrl_dat_r = {24'd0, cmd};
                `C_DATA0:   ctrl_dat_r = data0;
                `C_DATA1:   ctrl_dat_r = data1;
                default:    ctrl_dat_r = '0;
            endcase
        end
    end

    always_ff @(posedge sys) begin
        if (reset) begin
            state     <= port_idle;
            ctrl_ack  <= 1'b0;
            cpu_ready <= 1'b0;
            cpu_busy  <= 1'b0;
        end else begin
            ctrl_ack <= ctrl_access;
            state    <= ctrl_access ? port_wait : port_idle;

            if (ctrl_write && (ctrl_adr == `C_STATUS)) begin
                cpu_ready <= ctrl_dat_w[0];
                if (ctrl_dat_w[1]) begin
                    cpu_busy <= 1'b0;  // command done.
                end
            end

            // a new command outranks a clear in the same cycle.
            if (cmd_request) begin
                cpu_busy <= 1'b1;
            end
        end
    end

    a_data_strobe: assert property (@(posedge sys) disable iff (reset)
        (|data_write) |-> $onehot(data_write) ##1 ctrl_ack)
        else $error("bad data write strobe.");

endmodule

/* logic/mailbox_macros.svh */
`ifndef MAILBOX_MACROS_SVH
`define MAILBOX_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed identification
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MAILBOX_VERSION 32'h4D42_0102

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host register map, 16-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define H_STATUS    3'd0
`define H_COMMAND   3'd1
`define H_DATA0_H   3'd2
`define H_DATA0_L   3'd3
`define H_DATA1_H   3'd4
`define H_DATA1_L   3'd5
`define H_VERSION_H 3'd6
`define H_VERSION_L 3'd7

// controller register map, 32-bit words.
`define C_STATUS    2'd0
`define C_COMMAND   2'd1
`define C_DATA0     2'd2
`define C_DATA1     2'd3

`endif

/* logic/mailbox_pkg.sv */
package mailbox_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and register widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] host_word_t;  // host bus data.

    typedef logic [31:0] ctrl_word_t;  // controller data, one mailbox word.

    typedef logic [7:0]  command_t;    // command code from host.

    typedef logic [2:0]  host_addr_t;  // host index, address bits 3:1.

    typedef logic [1:0]  ctrl_addr_t;  // controller register index.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slave states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // shared by both wishbone slaves.
    typedef enum logic {
        port_idle,  // waiting for cyc and stb.
        port_wait   // ack cycle, no new access.
    } port_state_t;

endpackage

/* logic/mailbox_regs.sv */
`timescale 1ns/1ps
`include "mailbox_macros.svh"

module mailbox_regs (
    input  logic                    sys,
    input  logic                    reset,
    input  logic                    host_cyc,
    input  logic                    host_stb,
    input  logic                    host_we,
    input  mailbox_pkg::host_addr_t host_adr,
    input  mailbox_pkg::host_word_t host_dat_w,
    output mailbox_pkg::host_word_t host_dat_r,
    output logic                    host_ack,
    output mailbox_pkg::command_t   cmd,
    output logic                    cmd_request,
    output mailbox_pkg::ctrl_word_t data0,
    output mailbox_pkg::ctrl_word_t data1,
    input  logic [1:0]              data_write,
    input  mailbox_pkg::ctrl_word_t data_wdata,
    input  logic                    cpu_ready,
    input  logic                    cpu_busy
);

    import mailbox_pkg::*;

    port_state_t state;
    logic        host_req;
    ctrl_word_t  version;

    assign host_req = host_cyc && host_stb;
    assign version  = `MAILBOX_VERSION;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        host_dat_r = '0;  // zero outside the ack cycle.
        if (host_ack) begin
            case (host_adr)
                `H_STATUS:    host_dat_r = {cpu_ready, cpu_busy, 14'd0};
                `H_COMMAND:   host_dat_r = {8'd0, cmd};
                `H_DATA0_H:   host_dat_r = data0[31:16];
                `H_DATA0_L:   host_dat_r = data0[15:0];
                `H_DATA1_H:   host_dat_r = data1[31:16];
                `H_DATA1_L:   host_dat_r = data1[15:0];
                `H_VERSION_H: host_dat_r = version[31:16];
                `H_VERSION_L: host_dat_r = version[15:0];
                default:      host_dat_r = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slave and write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys) begin
        if (reset) begin
            state       <= port_idle;
            host_ack    <= 1'b0;
            cmd_request <= 1'b0;
            cmd         <= '0;
            data0       <= '0;
            data1       <= '0;
        end else begin
            host_ack    <= 1'b0;
            cmd_request <= 1'b0;

            // controller results first, host half-words override below.
            if (data_write[0]) begin
                data0 <= data_wdata;
            end
            if (data_write[1]) begin
                data1 <= data_wdata;
            end

            case (state)
                port_idle: begin
                    if (host_req) begin
                        state    <= port_wait;
                        host_ack <= 1'b1;
                        if (host_we) begin
                            case (host_adr)
                                `H_COMMAND: begin
                                    cmd         <= host_dat_w[7:0];
                                    cmd_request <= 1'b1;  // pulses with ack.
                                end
                                `H_DATA0_H: data0[31:16] <= host_dat_w;
                                `H_DATA0_L: data0[15:0]  <= host_dat_w;
                                `H_DATA1_H: data1[31:16] <= host_dat_w;
                                `H_DATA1_L: data1[15:0]  <= host_dat_w;
                                default: ;  // status and version read only.
                            endcase
                        end
                    end
                end

                port_wait: begin
                    state <= port_idle;
                end

                default: state <= port_idle;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_ack_single: assert property (@(posedge sys) disable iff (reset)
        host_ack |=> !host_ack)
        else $error("host ack held for two cycles.");

    // request rides on the ack, busy follows one edge later.
    a_cmd_busy: assert property (@(posedge sys) disable iff (reset)
        cmd_request |-> host_ack ##1 cpu_busy)
        else $error("command request without ack or busy.");

endmodule

/* logic/mailbox_top.sv */
`timescale 1ns/1ps

module mailbox_top (
    input  logic                    sys,
    input  logic                    reset,
    input  logic                    host_cyc,
    input  logic                    host_stb,
    input  logic                    host_we,
    input  mailbox_pkg::host_addr_t host_adr,
    input  mailbox_pkg::host_word_t host_dat_w,
    output mailbox_pkg::host_word_t host_dat_r,
    output logic                    host_ack,
    input  logic                    ctrl_cyc,
    input  logic                    ctrl_stb,
    input  logic                    ctrl_we,
    input  mailbox_pkg::ctrl_addr_t ctrl_adr,
    input  mailbox_pkg::ctrl_word_t ctrl_dat_w,
    output mailbox_pkg::ctrl_word_t ctrl_dat_r,
    output logic                    ctrl_ack,
    output logic                    cmd_request
);

    import mailbox_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // links between host and controller sides
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    command_t   cmd;
    ctrl_word_t data0;
    ctrl_word_t data1;
    logic [1:0] data_write;
    ctrl_word_t data_wdata;
    logic       cpu_ready;
    logic       cpu_busy;

    mailbox_regs u_regs (
        .sys         (sys),
        .reset       (reset),
        .host_cyc    (host_cyc),
        .host_stb    (host_stb),
        .host_we     (host_we),
        .host_adr    (host_adr),
        .host_dat_w  (host_dat_w),
        .host_dat_r  (host_dat_r),
        .host_ack    (host_ack),
        .cmd         (cmd),
        .cmd_request (cmd_request),
        .data0       (data0),
        .data1       (data1),
        .data_write  (data_write),
        .data_wdata  (data_wdata),
        .cpu_ready   (cpu_ready),
        .cpu_busy    (cpu_busy)
    );

    controller_port u_port (
        .sys         (sys),
        .reset       (reset),
        .ctrl_cyc    (ctrl_cyc),
        .ctrl_stb    (ctrl_stb),
        .ctrl_we     (ctrl_we),
        .ctrl_adr    (ctrl_adr),
        .ctrl_dat_w  (ctrl_dat_w),
        .ctrl_dat_r  (ctrl_dat_r),
        .ctrl_ack    (ctrl_ack),
        .cmd         (cmd),
        .cmd_request (cmd_request),
        .data0       (data0),
        .data1       (data1),
        .data_write  (data_write),
        .data_wdata  (data_wdata),
        .cpu_ready   (cpu_ready),
        .cpu_busy    (cpu_busy)
    );

endmodule

/* project.f */
+incdir+logic
logic/mailbox_pkg.sv
logic/mailbox_regs.sv
logic/controller_port.sv
logic/mailbox_top.sv
bench/tb_clock_gen.sv
bench/tb_mailbox_checks.sv
bench/tb_mailbox.sv
